// File: Bender.yml
package:
  name: fetch_top

export_include_dirs:
  - .

sources:
  - files:
      - fetch_pkg.sv
      - icache.sv
      - imem_tracker.sv
      - fetch_stage.sv
      - fetch_top.sv
  - target: test
    files:
      - tb_fetch_top.sv

// File: fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// address width of the core
`define XLEN 32

// one instruction, two of them make a memory line
`define INST_WIDTH 32

// request edge to data cycle, must stay below 255 (all ones marks an idle countdown)
`define MEM_LATENCY_IN_CYCLES 4

`define FETCH_WIDTH 3        // slots per cycle, the slot logic is written for three

`define ICACHE_LINES 8       // direct mapped, index is addr[5:3]

`endif

// File: fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

    // byte address in instruction space
    typedef logic [`XLEN-1:0] addr_t;

    typedef logic [`INST_WIDTH-1:0] inst_t;       // one fetched instruction

    // 64 bit memory line, low word at the lower address
    typedef logic [2*`INST_WIDTH-1:0] line_t;

    // line index into the icache, addr[5:3]
    typedef logic [$clog2(`ICACHE_LINES)-1:0] cache_index_t;

    typedef logic [`XLEN-7:0] cache_tag_t;        // addr[31:6]

    // outstanding read counter
    // counts down to 0 on the data cycle, all ones when idle
    typedef logic [7:0] countdown_t;

endpackage

// File: fetch_stage.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

// three wide fetch with slot 2 oldest and valid bits forming a prefix from slot 2
module fetch_stage
    import fetch_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            take_branch,
    input  addr_t                           target_pc,      // slot 2 pc after a branch
    input  logic                            mem_busy,       // blocks new memory requests
    input  line_t                           imem_data,
    output addr_t                           imem_addr,
    output logic                            imem_req,
    output logic  [`FETCH_WIDTH-1:0]        if_valid,
    output addr_t [`FETCH_WIDTH-1:0]        if_pc,
    output inst_t [`FETCH_WIDTH-1:0]        if_inst
);

    addr_t [2:0]    pc_q;
    addr_t [2:0]    pc_next;
    logic  [2:0]    hit;
    logic  [2:0]    arrived;
    logic  [2:0]    data_ready;
    inst_t [2:0]    cache_inst;
    logic  [1:0]    shift;
    logic           fill_en;
    addr_t          fill_addr;
    logic           same_21, same_20, same_10;    // slots sharing a memory line

    assign same_21 = pc_q[2][`XLEN-1:3] == pc_q[1][`XLEN-1:3];
    assign same_20 = pc_q[2][`XLEN-1:3] == pc_q[0][`XLEN-1:3];
    assign same_10 = pc_q[1][`XLEN-1:3] == pc_q[0][`XLEN-1:3];

    // ready when cached, own read landed or an older slot's read of the same line landed
    assign data_ready[2] = hit[2] | arrived[2];
    assign data_ready[1] = hit[1] | arrived[1] | (arrived[2] & same_21);
    assign data_ready[0] = hit[0] | arrived[0] | (arrived[1] & same_10)
                         | (arrived[2] & same_20);

    assign if_valid[2] = data_ready[2];
    assign if_valid[1] = if_valid[2] & data_ready[1];
    assign if_valid[0] = if_valid[1] & data_ready[0];
    assign if_pc       = pc_q;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            if (hit[i])
                if_inst[i] = cache_inst[i];
            else if (pc_q[i][2])                  // upper word of the landing line
                if_inst[i] = imem_data[2*`INST_WIDTH-1:`INST_WIDTH];
            else
                if_inst[i] = imem_data[`INST_WIDTH-1:0];
        end
    end

    // oldest not ready slot moves up to slot 2
    always_comb begin
        shift = 2'd0;
        if (take_branch) begin
            pc_next[2] = target_pc;           // countdowns stay where they are
        end
        else if (!data_ready[2]) begin
            pc_next[2] = pc_q[2];
        end
        else if (!data_ready[1]) begin
            pc_next[2] = pc_q[1];
            shift      = 2'd1;
        end
        else if (!data_ready[0]) begin
            pc_next[2] = pc_q[0];
            shift      = 2'd2;
        end
        else begin
            pc_next[2] = pc_q[0] + addr_t'(4);  // all three retire
        end
        pc_next[1] = pc_next[2] + addr_t'(4);
        pc_next[0] = pc_next[2] + addr_t'(8);
    end

    always_ff @(posedge clock) begin
        if (reset)
            pc_q <= {addr_t'(0), addr_t'(4), addr_t'(8)};
        else
            pc_q <= pc_next;
    end

    icache u_icache (
        .clock      (clock),
        .reset      (reset),
        .rd_pc      (pc_q),
        .hit        (hit),
        .rd_inst    (cache_inst),
        .fill_en    (fill_en),
        .fill_addr  (fill_addr),
        .fill_data  (imem_data)               // memory line goes straight in
    );

    imem_tracker u_imem_tracker (
        .clock      (clock),
        .reset      (reset),
        .slot_pc    (pc_q),
        .hit        (hit),
        .ready      (data_ready),
        .shift      (shift),
        .mem_busy   (mem_busy),
        .arrived    (arrived),
        .imem_addr  (imem_addr),
        .imem_req   (imem_req),
        .fill_en    (fill_en),
        .fill_addr  (fill_addr)
    );

    // a valid slot that missed the cache takes its word from the line landing now
    for (genvar g = 0; g < 3; g++) begin : g_chk
        a_miss_fed: assert property (
            @(posedge clock) disable iff (reset)
            (if_valid[g] && !hit[g])
                |-> (fill_en && (fill_addr[`XLEN-1:3] == pc_q[g][`XLEN-1:3]))
        );
    end

endmodule

// File: fetch_stimulus.txt
# m <byte address hex> <instruction hex> : memory image word
# c <cycles> <take_branch> <target_pc hex> <mem_busy> : inputs held for that many cycles
m 00000000 00100093
m 00000004 00200113
m 00000008 002081b3
m 0000000c 40208233
m 00000010 0020f2b3
m 00000014 0020e333
m 00000018 0020c3b3
m 0000001c 00209433
m 00000020 0020d4b3
m 00000024 00302023
m 00000028 00002503
m 0000002c 00150513
m 00000030 00000013
m 00000034 fe0008e3
m 00000038 0000006f
m 0000003c 00008067
c 12 0 00000000 0
c 1 1 00000000 0
c 6 0 00000000 1
c 10 0 00000000 0
c 1 1 00000024 0
c 3 0 00000000 0
c 2 0 00000000 1
c 1 1 00000010 1
c 8 0 00000000 0
c 1 1 00002000 0
c 15 0 00000000 0
c 1 1 00000004 0
c 4 0 00000000 1
c 12 0 00000000 0

// File: fetch_top.f
+incdir+.
fetch_pkg.sv
icache.sv
imem_tracker.sv
fetch_stage.sv
fetch_top.sv
tb_fetch_top.sv

// File: fetch_top.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

// fetch front end, memory sits outside
module fetch_top
    import fetch_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            take_branch,
    input  addr_t                           target_pc,
    input  logic                            mem_busy,
    input  line_t                           imem_data,      // line answered by memory
    output addr_t                           imem_addr,      // line aligned request
    output logic                            imem_req,       // single cycle strobe
    output logic  [`FETCH_WIDTH-1:0]        if_valid,
    output addr_t [`FETCH_WIDTH-1:0]        if_pc,
    output inst_t [`FETCH_WIDTH-1:0]        if_inst
);

    fetch_stage u_fetch_stage (
        .clock          (clock),
        .reset          (reset),
        .take_branch    (take_branch),
        .target_pc      (target_pc),
        .mem_busy       (mem_busy),
        .imem_data      (imem_data),
        .imem_addr      (imem_addr),
        .imem_req       (imem_req),
        .if_valid       (if_valid),
        .if_pc          (if_pc),
        .if_inst        (if_inst)   // no back-pressure, dispatch takes every valid slot
    );

endmodule

// File: icache.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

// direct mapped instruction cache
// three combinational read ports, one fill port written at the edge
module icache
    import fetch_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  addr_t [2:0]         rd_pc,          // slot 2 oldest
    output logic  [2:0]         hit,
    output inst_t [2:0]         rd_inst,
    input  logic                fill_en,        // line arrived from memory this cycle
    input  addr_t               fill_addr,      // line aligned
    input  line_t               fill_data
);

    line_t                      data_q [`ICACHE_LINES];
    cache_tag_t                 tag_q  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]   valid_q;

    cache_index_t               fill_idx;
    cache_tag_t                 fill_tag;
    cache_index_t [2:0]         rd_idx;
    cache_tag_t   [2:0]         rd_tag;

    assign fill_idx = fill_addr[5:3];
    assign fill_tag = fill_addr[`XLEN-1:6];

    // read ports
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            rd_idx[i] = rd_pc[i][5:3];
            rd_tag[i] = rd_pc[i][`XLEN-1:6];
            hit[i]    = valid_q[rd_idx[i]] && (tag_q[rd_idx[i]] == rd_tag[i]);
            // bit 2 picks the word inside the line
            if (rd_pc[i][2])
                rd_inst[i] = data_q[rd_idx[i]][2*`INST_WIDTH-1:`INST_WIDTH];
            else
                rd_inst[i] = data_q[rd_idx[i]][`INST_WIDTH-1:0];
        end
    end

    // valid bits, the only state cleared by reset
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end
        else if (fill_en) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    // line storage
    always_ff @(posedge clock) begin
        if (fill_en) begin
            data_q[fill_idx] <= fill_data;
            tag_q[fill_idx]  <= fill_tag;      // old line in this index is simply replaced
        end
    end

    // the tracker fills whole lines only
    a_fill_aligned: assert property (
        @(posedge clock) disable iff (reset)
        fill_en |-> (fill_addr[2:0] == 3'b000)
    );

endmodule

// File: imem_tracker.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

// tracks outstanding instruction memory reads with one countdown per fetch slot
module imem_tracker
    import fetch_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  addr_t [2:0]         slot_pc,        // slot 2 oldest
    input  logic  [2:0]         hit,
    input  logic  [2:0]         ready,          // data ready per slot from fetch_stage
    input  logic  [1:0]         shift,          // slots retired ahead of the oldest not ready
    input  logic                mem_busy,
    output logic  [2:0]         arrived,        // own read for the slot's line lands now
    output addr_t               imem_addr,
    output logic                imem_req,
    output logic                fill_en,
    output addr_t               fill_addr
);

    localparam countdown_t CNT_IDLE = '1;
    localparam countdown_t CNT_LOAD = countdown_t'(`MEM_LATENCY_IN_CYCLES);

    countdown_t [2:0]   cnt_q;
    countdown_t [2:0]   cnt_next;
    addr_t      [2:0]   line_q;             // line each countdown was started for
    addr_t      [2:0]   line_next;
    logic       [2:0]   idle;
    logic       [2:0]   pending;            // slot's line already in flight somewhere
    logic       [2:0]   eligible;
    addr_t              issue_line;

    function automatic addr_t line_of(addr_t a);
        return {a[`XLEN-1:3], 3'b000};
    endfunction

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            idle[i]    = cnt_q[i] > CNT_LOAD;
            // a stale countdown lands too but carries another line
            arrived[i] = (cnt_q[i] == '0) && (line_q[i] == line_of(slot_pc[i]));
            pending[i] = 1'b0;
            for (int k = 0; k < 3; k++) begin
                if ((cnt_q[k] <= CNT_LOAD) && (line_q[k] == line_of(slot_pc[i])))
                    pending[i] = 1'b1;
            end
            eligible[i] = !ready[i] && idle[i] && !pending[i];
        end
    end

    // one request per cycle for the oldest eligible slot (slot 2 checked last)
    always_comb begin
        imem_req   = 1'b0;
        issue_line = line_of(slot_pc[2]);
        for (int i = 0; i < 3; i++) begin
            if (eligible[i]) begin
                imem_req   = 1'b1;
                issue_line = line_of(slot_pc[i]);
            end
        end
        if (mem_busy)
            imem_req = 1'b0;                // only delays the issue
    end

    assign imem_addr = issue_line;

    // the landed line goes into the cache (distinct lines never land together)
    always_comb begin
        fill_en   = 1'b0;
        fill_addr = line_q[2];
        for (int i = 0; i < 3; i++) begin
            if (cnt_q[i] == '0) begin
                fill_en   = 1'b1;
                fill_addr = line_q[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            if (idle[i] || cnt_q[i] == '0)
                cnt_next[i] = CNT_IDLE;
            else
                cnt_next[i] = cnt_q[i] - countdown_t'(1);
            line_next[i] = line_q[i];
            // younger slots on the issued line share the read
            if (imem_req && eligible[i] && line_of(slot_pc[i]) == issue_line) begin
                cnt_next[i]  = CNT_LOAD;
                line_next[i] = issue_line;
            end
        end
        case (shift)
            2'd1: begin
                cnt_next[2]  = cnt_next[1];
                cnt_next[1]  = cnt_next[0];
                cnt_next[0]  = CNT_IDLE;
                line_next[2] = line_next[1];
                line_next[1] = line_next[0];
            end
            2'd2: begin
                cnt_next[2]  = cnt_next[0];
                cnt_next[1]  = CNT_IDLE;
                cnt_next[0]  = CNT_IDLE;
                line_next[2] = line_next[0];
            end
            default: ;                      // nothing retired or all three did
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset)
            cnt_q <= {3{CNT_IDLE}};
        else
            cnt_q <= cnt_next;
    end

    always_ff @(posedge clock) begin
        line_q <= line_next;
    end

    // the requesting slot keeps its countdown through the retire shift
    a_load_on_req: assert property (
        @(posedge clock) disable iff (reset)
        imem_req |=> (cnt_q[2] == CNT_LOAD) || (cnt_q[1] == CNT_LOAD)
                     || (cnt_q[0] == CNT_LOAD)
    );

    // no read starts while memory is busy
    a_no_load_busy: assert property (
        @(posedge clock) disable iff (reset)
        mem_busy |=> (cnt_q[2] != CNT_LOAD) && (cnt_q[1] != CNT_LOAD)
                     && (cnt_q[0] != CNT_LOAD)
    );

    for (genvar g = 0; g < 3; g++) begin : g_chk
        // a slot on the line just filled must hit in the cache next cycle
        a_fill_hits: assert property (
            @(posedge clock) disable iff (reset)
            fill_en |=> (slot_pc[g][`XLEN-1:3] != $past(fill_addr[`XLEN-1:3])) || hit[g]
        );
    end

endmodule

// File: tb_fetch_top.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

// testbench for the three wide fetch front end with a model of the instruction memory
module tb_fetch_top
    import fetch_pkg::*;
();

    localparam int TIMEOUT   = 200;                 // cycles allowed without a valid slot
    localparam int LATENCY   = `MEM_LATENCY_IN_CYCLES;
    localparam int IMG_WORDS = 256;                 // image covers the first 1 KiB

    logic           clock;
    logic           reset;
    logic           take_branch;
    addr_t          target_pc;
    logic           mem_busy;
    line_t          imem_data;
    addr_t          imem_addr;
    logic           imem_req;
    logic  [2:0]    if_valid;
    addr_t [2:0]    if_pc;
    inst_t [2:0]    if_inst;

    inst_t          img [IMG_WORDS];
    int             cmd_cycles_q [$];
    logic           cmd_branch_q [$];
    addr_t          cmd_target_q [$];
    logic           cmd_busy_q   [$];

    // reads in flight with the oldest first
    addr_t          req_addr_q [$];
    int             req_due_q  [$];                 // cycle that sees the data
    int             req_br_q   [$];                 // branch count when issued

    // line the cache must hold per index
    addr_t          res_line  [`ICACHE_LINES];
    logic           res_known [`ICACHE_LINES];

    addr_t          expect_pc;                      // next program order pc
    int             cyc;
    int             branch_cnt;
    int             idle_cycles;
    logic           seen_after_branch;

    fetch_top dut (
        .clock          (clock),
        .reset          (reset),
        .take_branch    (take_branch),
        .target_pc      (target_pc),
        .mem_busy       (mem_busy),
        .imem_data      (imem_data),
        .imem_addr      (imem_addr),
        .imem_req       (imem_req),
        .if_valid       (if_valid),
        .if_pc          (if_pc),
        .if_inst        (if_inst)
    );

    always #20 clock = ~clock;                      // 40 ns period

    // fill pattern over the whole address for words missing from the image
    function automatic inst_t fill_word(addr_t a);
        return a ^ 32'h5a5a_0013;
    endfunction

    function automatic inst_t image_word(addr_t a);
        if (a < addr_t'(4 * IMG_WORDS))
            return img[a[9:2]];
        return fill_word(a);
    endfunction

    // low word at the lower address
    function automatic line_t image_line(addr_t a);
        return {image_word(a + addr_t'(4)), image_word(a)};
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout();
        $display("no instruction arrived within %0d cycles", TIMEOUT);
        $display("TB FAILED");
        $fatal(1, "fetch timeout");
    endtask

    task automatic read_stimulus();
        int     fd;
        int     n;
        int     br;
        int     busy;
        addr_t  a;
        inst_t  w;
        string  line;
        fd = $fopen("fetch_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file fetch_stimulus.txt");
            $display("TB FAILED");
            $fatal(1, "missing stimulus");
        end
        else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    if ($sscanf(line, "m %h %h", a, w) == 2 && a < addr_t'(4 * IMG_WORDS)) begin
                        img[a[9:2]] = w;
                    end
                    else if ($sscanf(line, "c %d %d %h %d", n, br, a, busy) == 4) begin
                        cmd_cycles_q.push_back(n);
                        cmd_branch_q.push_back(br != 0);
                        cmd_target_q.push_back(a);
                        cmd_busy_q.push_back(busy != 0);
                    end
                    else begin
                        $display("stimulus line could not be read: %s", line);
                        $display("TB FAILED");
                        $fatal(1, "bad stimulus");
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // memory answers the read whose data cycle starts now
    task automatic present_memory();
        addr_t a;
        imem_data = '0;
        if (req_due_q.size() > 0 && req_due_q[0] == cyc) begin
            a = req_addr_q.pop_front();
            imem_data = image_line(a);
            if (req_br_q[0] == branch_cnt) begin
                res_line[a[5:3]]  = a;              // fill lands at the next edge
                res_known[a[5:3]] = 1'b1;
            end
            else begin
                res_known[a[5:3]] = 1'b0;           // a branch in flight may drop the fill
            end
            req_due_q.delete(0);
            req_br_q.delete(0);
        end
    endtask

    // checks at the falling edge when all outputs are stable
    task automatic observe();
        int     i;
        addr_t  line;
        logic   dup;
        logic   prefix;
        if (imem_req) begin
            check_equal(mem_busy, 1'b0, "imem_req high while mem_busy");
            check_equal(imem_addr[2:0], 3'b000, "imem_addr not line aligned");
            line = imem_addr;
            dup  = res_known[line[5:3]] && (res_line[line[5:3]] == line);
            for (i = 0; i < req_addr_q.size(); i++) begin
                if (req_addr_q[i] == line && req_br_q[i] == branch_cnt)
                    dup = 1'b1;                     // same line already on its way
            end
            check_equal(dup, 1'b0, "line requested again with no branch cutting its fill");
            req_addr_q.push_back(line);
            req_due_q.push_back(cyc + 1 + LATENCY); // strobe counts at the next edge
            req_br_q.push_back(branch_cnt);
        end
        prefix = (if_valid == 3'b000) || (if_valid == 3'b100)
              || (if_valid == 3'b110) || (if_valid == 3'b111);
        check_equal(prefix, 1'b1, "if_valid not a prefix from slot 2");
        check_equal(if_pc[1], if_pc[2] + addr_t'(4), "if_pc slot 1 not slot 2 plus 4");
        check_equal(if_pc[0], if_pc[2] + addr_t'(8), "if_pc slot 0 not slot 2 plus 8");
        for (i = 2; i >= 0; i--) begin
            if (if_valid[i]) begin
                check_equal(if_pc[i], expect_pc, $sformatf("if_pc of slot %0d", i));
                check_equal(if_inst[i], image_word(if_pc[i]),
                            $sformatf("if_inst of slot %0d", i));
                expect_pc = expect_pc + addr_t'(4);
                seen_after_branch = 1'b1;
            end
        end
        if (if_valid[2])
            idle_cycles = 0;
        else
            idle_cycles++;
        if (idle_cycles >= TIMEOUT)
            report_timeout();
        if (take_branch) begin
            branch_cnt++;
            expect_pc = target_pc;                  // old path ends here
            seen_after_branch = 1'b0;
        end
    endtask

    // one clock cycle with inputs applied 2 ns after the rising edge
    task automatic step(input logic br, input addr_t tgt, input logic busy);
        take_branch = br;
        target_pc   = tgt;
        mem_busy    = busy;
        present_memory();
        @(negedge clock);
        observe();
        @(posedge clock);
        cyc++;
        #2;
    endtask

    // run on until the current path delivers something
    task automatic drain_fetch();
        int n;
        n = 0;
        while (!seen_after_branch) begin
            if (n >= TIMEOUT)
                report_timeout();
            step(1'b0, '0, 1'b0);
            n++;
        end
    endtask

    initial begin
        int k;
        clock             = 1'b0;
        reset             = 1'b1;
        take_branch       = 1'b0;
        target_pc         = '0;
        mem_busy          = 1'b0;
        imem_data         = '0;
        expect_pc         = '0;
        cyc               = 0;
        branch_cnt        = 0;
        idle_cycles       = 0;
        seen_after_branch = 1'b0;
        for (k = 0; k < IMG_WORDS; k++)
            img[k] = fill_word(addr_t'(4 * k));
        for (k = 0; k < `ICACHE_LINES; k++)
            res_known[k] = 1'b0;
        read_stimulus();
        repeat (4) @(posedge clock);
        #2;
        reset = 1'b0;
        while (cmd_cycles_q.size() > 0) begin
            repeat (cmd_cycles_q[0]) step(cmd_branch_q[0], cmd_target_q[0], cmd_busy_q[0]);
            cmd_cycles_q.delete(0);
            cmd_branch_q.delete(0);
            cmd_target_q.delete(0);
            cmd_busy_q.delete(0);
        end
        drain_fetch();
        $display("TB PASSED");
        $finish;
    end

endmodule
